// File: design/alu.sv
module alu (
  input  mips_isa_pkg::op_t   op,
  input  mips_isa_pkg::word_t a,
  input  mips_isa_pkg::word_t b,
  output mips_isa_pkg::word_t result
);

  always_comb begin
    case (op)
      // Loads and stores use the sum as address
      mips_isa_pkg::op_addu,
      mips_isa_pkg::op_lw,
      mips_isa_pkg::op_sw:   result = a + b;
      mips_isa_pkg::op_subu: result = a - b;
      mips_isa_pkg::op_ori:  result = a | b;
      mips_isa_pkg::op_lui:  result = {b[15:0], 16'h0000};
      default:               result = '0;
    endcase
  end

endmodule

// File: design/fetch_stage.sv
module fetch_stage #(
  parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_3000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                hold,
  input  mips_isa_pkg::op_t   op,
  input  logic                equal,
  input  mips_isa_pkg::word_t pc_d,
  input  mips_isa_pkg::word_t imm,
  input  logic [25:0]         target,
  input  mips_isa_pkg::word_t jump_base,
  output mips_isa_pkg::word_t pc
);

  mips_isa_pkg::word_t next_pc;

  // Control flow follows the instruction in D, so the slot in F always runs
  always_comb begin
    next_pc = pc + 32'd4;
    if (op == mips_isa_pkg::op_beq && equal) begin
      next_pc = pc_d + 32'd4 + {imm[29:0], 2'b00};
    end else if (op == mips_isa_pkg::op_j || op == mips_isa_pkg::op_jal) begin
      next_pc = {jump_base[31:28], target, 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!hold) begin
      pc <= next_pc;
    end
  end

endmodule

// File: design/hazard_unit.sv
module hazard_unit (
  input  mips_pipe_pkg::reg_idx_t d_rs,
  input  mips_pipe_pkg::reg_idx_t d_rt,
  input  mips_pipe_pkg::stage_t   d_rs_use,
  input  mips_pipe_pkg::stage_t   d_rt_use,
  input  mips_pipe_pkg::reg_idx_t e_rs,
  input  mips_pipe_pkg::reg_idx_t e_rt,
  input  mips_pipe_pkg::reg_idx_t e_dest,
  input  mips_pipe_pkg::stage_t   e_rs_use,
  input  mips_pipe_pkg::stage_t   e_rt_use,
  input  mips_pipe_pkg::stage_t   e_ready,
  input  mips_pipe_pkg::reg_idx_t m_rt,
  input  mips_pipe_pkg::reg_idx_t m_dest,
  input  mips_pipe_pkg::stage_t   m_ready,
  input  mips_pipe_pkg::reg_idx_t w_dest,
  input  logic                    w_we,
  output logic [1:0]              fwd_d_rs,
  output logic [1:0]              fwd_d_rt,
  output logic [1:0]              fwd_e_rs,
  output logic [1:0]              fwd_e_rt,
  output logic [1:0]              fwd_m_rt,
  output logic                    stall
);

  logic e_ok;
  logic m_ok;

  function automatic logic hit(input mips_pipe_pkg::reg_idx_t src,
                               input mips_pipe_pkg::stage_t   use_at,
                               input mips_pipe_pkg::reg_idx_t dst,
                               input logic                    ok);
    return ok && (use_at != mips_pipe_pkg::STAGE_NONE) && (dst != '0) && (src == dst);
  endfunction

  // Youngest producer first
  function automatic logic [1:0] pick(input logic from_e, input logic from_m,
                                      input logic from_w);
    if (from_e) return mips_pipe_pkg::FWD_E;
    if (from_m) return mips_pipe_pkg::FWD_M;
    if (from_w) return mips_pipe_pkg::FWD_W;
    return mips_pipe_pkg::FWD_RF;
  endfunction

  // Producer at stage pos still lacks its result when the D consumer reaches use_at
  function automatic logic late(input mips_pipe_pkg::reg_idx_t src,
                                input mips_pipe_pkg::stage_t   use_at,
                                input mips_pipe_pkg::reg_idx_t dst,
                                input mips_pipe_pkg::stage_t   rdy,
                                input int                      pos);
    return hit(src, use_at, dst, rdy != mips_pipe_pkg::STAGE_NONE) &&
           (int'(rdy) + 1 >= pos + int'(use_at));
  endfunction

  // A result sits in a stage register once its ready stage is behind it
  assign e_ok = (e_ready == mips_pipe_pkg::STAGE_D);
  assign m_ok = (m_ready == mips_pipe_pkg::STAGE_D) || (m_ready == mips_pipe_pkg::STAGE_E);

  ////////////////////////////////
  // Forward selects
  ////////////////////////////////
  assign fwd_d_rs = pick(hit(d_rs, d_rs_use, e_dest, e_ok),
                         hit(d_rs, d_rs_use, m_dest, m_ok),
                         hit(d_rs, d_rs_use, w_dest, w_we));
  assign fwd_d_rt = pick(hit(d_rt, d_rt_use, e_dest, e_ok),
                         hit(d_rt, d_rt_use, m_dest, m_ok),
                         hit(d_rt, d_rt_use, w_dest, w_we));
  assign fwd_e_rs = pick(1'b0, hit(e_rs, e_rs_use, m_dest, m_ok),
                         hit(e_rs, e_rs_use, w_dest, w_we));
  assign fwd_e_rt = pick(1'b0, hit(e_rt, e_rt_use, m_dest, m_ok),
                         hit(e_rt, e_rt_use, w_dest, w_we));
  assign fwd_m_rt = pick(1'b0, 1'b0, hit(m_rt, mips_pipe_pkg::STAGE_M, w_dest, w_we));

  ////////////////////////////////
  // Stall
  ////////////////////////////////
  assign stall = late(d_rs, d_rs_use, e_dest, e_ready, int'(mips_pipe_pkg::STAGE_E)) ||
                 late(d_rt, d_rt_use, e_dest, e_ready, int'(mips_pipe_pkg::STAGE_E)) ||
                 late(d_rs, d_rs_use, m_dest, m_ready, int'(mips_pipe_pkg::STAGE_M)) ||
                 late(d_rt, d_rt_use, m_dest, m_ready, int'(mips_pipe_pkg::STAGE_M));

endmodule

// File: design/mips.sv
module mips #(
  parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_3000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mips_isa_pkg::word_t     i_inst_rdata,
  input  mips_isa_pkg::word_t     m_data_rdata,
  output mips_isa_pkg::word_t     i_inst_addr,
  output mips_isa_pkg::word_t     m_data_addr,
  output mips_isa_pkg::word_t     m_data_wdata,
  output logic [3:0]              m_data_byteen,
  output mips_isa_pkg::word_t     m_inst_addr,
  output logic                    w_grf_we,
  output mips_pipe_pkg::reg_idx_t w_grf_addr,
  output mips_isa_pkg::word_t     w_grf_wdata,
  output mips_isa_pkg::word_t     w_inst_addr
);

  mips_pipe_pkg::fd_payload_t fd_d, fd_q;
  mips_pipe_pkg::de_payload_t de_d, de_q;
  mips_pipe_pkg::em_payload_t em_d, em_q;
  mips_pipe_pkg::mw_payload_t mw_d, mw_q;

  mips_isa_pkg::word_t pc;
  logic                stall;
  logic [1:0]          fwd_d_rs, fwd_d_rt, fwd_e_rs, fwd_e_rt, fwd_m_rt;

  mips_isa_pkg::op_t       d_op;
  mips_pipe_pkg::reg_idx_t d_rs, d_rt, d_dest;
  mips_pipe_pkg::stage_t   d_rs_use, d_rt_use, d_ready;
  logic                    d_imm_sign, d_is_store, d_is_load, d_equal;
  mips_isa_pkg::word_t     rf_rdata1, rf_rdata2, d_rs_val, d_rt_val, d_imm, d_pc_plus4;

  logic                e_use_imm;
  mips_isa_pkg::word_t e_rs_val, e_rt_val, alu_b, alu_result;
  mips_isa_pkg::word_t m_rt_val;
  mips_isa_pkg::word_t wb_data;

  function automatic mips_isa_pkg::word_t fwd_val(input logic [1:0]          sel,
                                                  input mips_isa_pkg::word_t keep,
                                                  input mips_isa_pkg::word_t e_val,
                                                  input mips_isa_pkg::word_t m_val,
                                                  input mips_isa_pkg::word_t w_val);
    case (sel)
      mips_pipe_pkg::FWD_E: return e_val;
      mips_pipe_pkg::FWD_M: return m_val;
      mips_pipe_pkg::FWD_W: return w_val;
      default:              return keep;
    endcase
  endfunction

  ////////////////////////////////
  // Fetch
  ////////////////////////////////
  fetch_stage #(.RESET_PC(RESET_PC)) fetch0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .hold     (stall),
    .op       (d_op),
    .equal    (d_equal),
    .pc_d     (fd_q.pc),
    .imm      (d_imm),
    .target   (fd_q.instr[25:0]),
    .jump_base(d_pc_plus4),
    .pc       (pc)
  );

  assign i_inst_addr = pc;
  assign fd_d        = '{instr: i_inst_rdata, pc: pc};

  pipe_reg #(.payload_t(mips_pipe_pkg::fd_payload_t)) fd_reg (
    .clk(clk), .rst_n(rst_n), .en(!stall), .clear(1'b0), .d(fd_d), .q(fd_q)
  );

  ////////////////////////////////
  // Decode
  ////////////////////////////////
  mips_decoder dec0 (
    .instr      (fd_q.instr),
    .op         (d_op),
    .rs         (d_rs),
    .rt         (d_rt),
    .dest       (d_dest),
    .rs_use     (d_rs_use),
    .rt_use     (d_rt_use),
    .ready_stage(d_ready),
    .imm_sign   (d_imm_sign),
    .is_store   (d_is_store),
    .is_load    (d_is_load)
  );

  reg_file rf0 (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (mw_q.we),
    .waddr (mw_q.dest),
    .wdata (wb_data),
    .raddr1(d_rs),
    .raddr2(d_rt),
    .rdata1(rf_rdata1),
    .rdata2(rf_rdata2)
  );

  // E forwards only a jal link value, M carries ALU or link results
  assign d_rs_val   = fwd_val(fwd_d_rs, rf_rdata1, de_q.result, em_q.result, wb_data);
  assign d_rt_val   = fwd_val(fwd_d_rt, rf_rdata2, de_q.result, em_q.result, wb_data);
  assign d_equal    = (d_rs_val == d_rt_val);
  assign d_imm      = d_imm_sign ? {{16{fd_q.instr[15]}}, fd_q.instr[15:0]}
                                 : {16'h0000, fd_q.instr[15:0]};
  assign d_pc_plus4 = fd_q.pc + 32'd4;

  assign de_d = '{
    op:       d_op,
    rs:       d_rs,
    rt:       d_rt,
    dest:     d_dest,
    rs_val:   d_rs_val,
    rt_val:   d_rt_val,
    imm:      d_imm,
    rs_use:   d_rs_use,
    rt_use:   d_rt_use,
    ready:    d_ready,
    result:   (d_op == mips_isa_pkg::op_jal) ? fd_q.pc + 32'd8 : '0,
    pc:       fd_q.pc,
    is_load:  d_is_load,
    is_store: d_is_store
  };

  // Bubble into E while the load result is not yet reachable
  pipe_reg #(.payload_t(mips_pipe_pkg::de_payload_t)) de_reg (
    .clk(clk), .rst_n(rst_n), .en(1'b1), .clear(stall), .d(de_d), .q(de_q)
  );

  hazard_unit haz0 (
    .d_rs    (d_rs),
    .d_rt    (d_rt),
    .d_rs_use(d_rs_use),
    .d_rt_use(d_rt_use),
    .e_rs    (de_q.rs),
    .e_rt    (de_q.rt),
    .e_dest  (de_q.dest),
    .e_rs_use(de_q.rs_use),
    .e_rt_use(de_q.rt_use),
    .e_ready (de_q.ready),
    .m_rt    (em_q.rt),
    .m_dest  (em_q.dest),
    .m_ready (em_q.ready),
    .w_dest  (mw_q.dest),
    .w_we    (mw_q.we),
    .fwd_d_rs(fwd_d_rs),
    .fwd_d_rt(fwd_d_rt),
    .fwd_e_rs(fwd_e_rs),
    .fwd_e_rt(fwd_e_rt),
    .fwd_m_rt(fwd_m_rt),
    .stall   (stall)
  );

  ////////////////////////////////
  // Execute
  ////////////////////////////////
  assign e_rs_val  = fwd_val(fwd_e_rs, de_q.rs_val, '0, em_q.result, wb_data);
  assign e_rt_val  = fwd_val(fwd_e_rt, de_q.rt_val, '0, em_q.result, wb_data);
  assign e_use_imm = de_q.is_load || de_q.is_store ||
                     (de_q.op == mips_isa_pkg::op_ori) || (de_q.op == mips_isa_pkg::op_lui);
  assign alu_b     = e_use_imm ? de_q.imm : e_rt_val;

  alu alu0 (
    .op    (de_q.op),
    .a     (e_rs_val),
    .b     (alu_b),
    .result(alu_result)
  );

  assign em_d = '{
    op:     de_q.op,
    rt:     de_q.rt,
    dest:   de_q.dest,
    ready:  de_q.ready,
    result: (de_q.op == mips_isa_pkg::op_jal) ? de_q.result : alu_result,
    wdata:  e_rt_val,
    pc:     de_q.pc
  };

  pipe_reg #(.payload_t(mips_pipe_pkg::em_payload_t)) em_reg (
    .clk(clk), .rst_n(rst_n), .en(1'b1), .clear(1'b0), .d(em_d), .q(em_q)
  );

  ////////////////////////////////
  // Memory
  ////////////////////////////////
  assign m_rt_val      = fwd_val(fwd_m_rt, em_q.wdata, '0, '0, wb_data);
  assign m_data_addr   = em_q.result;
  assign m_data_wdata  = m_rt_val;
  assign m_data_byteen = (em_q.op == mips_isa_pkg::op_sw) ? 4'hf : 4'h0;
  assign m_inst_addr   = em_q.pc;

  assign mw_d = '{
    dest:    em_q.dest,
    we:      (em_q.ready != mips_pipe_pkg::STAGE_NONE),
    result:  em_q.result,
    rdata:   m_data_rdata,
    is_load: (em_q.op == mips_isa_pkg::op_lw),
    pc:      em_q.pc
  };

  pipe_reg #(.payload_t(mips_pipe_pkg::mw_payload_t)) mw_reg (
    .clk(clk), .rst_n(rst_n), .en(1'b1), .clear(1'b0), .d(mw_d), .q(mw_q)
  );

  ////////////////////////////////
  // Write-back and trace
  ////////////////////////////////
  assign wb_data     = mw_q.is_load ? mw_q.rdata : mw_q.result;
  assign w_grf_we    = mw_q.we;
  assign w_grf_addr  = mw_q.dest;
  assign w_grf_wdata = wb_data;
  assign w_inst_addr = mw_q.pc;

endmodule

// File: design/mips_decoder.sv
module mips_decoder (
  input  mips_isa_pkg::word_t     instr,
  output mips_isa_pkg::op_t       op,
  output mips_pipe_pkg::reg_idx_t rs,
  output mips_pipe_pkg::reg_idx_t rt,
  output mips_pipe_pkg::reg_idx_t dest,
  output mips_pipe_pkg::stage_t   rs_use,
  output mips_pipe_pkg::stage_t   rt_use,
  output mips_pipe_pkg::stage_t   ready_stage,
  output logic                    imm_sign,
  output logic                    is_store,
  output logic                    is_load
);

  mips_isa_pkg::instr_t f;

  assign f  = instr;
  assign rs = f.rs;
  assign rt = f.rt;

  // Opcode and function decode, anything unknown becomes a nop
  always_comb begin
    op = mips_isa_pkg::op_nop;
    case (f.opcode)
      mips_isa_pkg::OPC_SPECIAL: begin
        if (f.funct == mips_isa_pkg::FN_ADDU) op = mips_isa_pkg::op_addu;
        if (f.funct == mips_isa_pkg::FN_SUBU) op = mips_isa_pkg::op_subu;
      end
      mips_isa_pkg::OPC_ORI: op = mips_isa_pkg::op_ori;
      mips_isa_pkg::OPC_LUI: op = mips_isa_pkg::op_lui;
      mips_isa_pkg::OPC_LW:  op = mips_isa_pkg::op_lw;
      mips_isa_pkg::OPC_SW:  op = mips_isa_pkg::op_sw;
      mips_isa_pkg::OPC_BEQ: op = mips_isa_pkg::op_beq;
      mips_isa_pkg::OPC_J:   op = mips_isa_pkg::op_j;
      mips_isa_pkg::OPC_JAL: op = mips_isa_pkg::op_jal;
      default: op = mips_isa_pkg::op_nop;
    endcase
  end

  // Register roles and timing per operation
  always_comb begin
    dest        = '0;
    rs_use      = mips_pipe_pkg::STAGE_NONE;
    rt_use      = mips_pipe_pkg::STAGE_NONE;
    ready_stage = mips_pipe_pkg::STAGE_NONE;
    case (op)
      mips_isa_pkg::op_addu, mips_isa_pkg::op_subu: begin
        dest        = f.rd;
        rs_use      = mips_pipe_pkg::STAGE_E;
        rt_use      = mips_pipe_pkg::STAGE_E;
        ready_stage = mips_pipe_pkg::STAGE_E;
      end
      mips_isa_pkg::op_ori: begin
        dest        = f.rt;
        rs_use      = mips_pipe_pkg::STAGE_E;
        ready_stage = mips_pipe_pkg::STAGE_E;
      end
      mips_isa_pkg::op_lui: begin
        dest        = f.rt;
        ready_stage = mips_pipe_pkg::STAGE_E;
      end
      mips_isa_pkg::op_lw: begin
        dest        = f.rt;
        rs_use      = mips_pipe_pkg::STAGE_E;
        ready_stage = mips_pipe_pkg::STAGE_M;
      end
      mips_isa_pkg::op_sw: begin
        rs_use = mips_pipe_pkg::STAGE_E;
        rt_use = mips_pipe_pkg::STAGE_M;
      end
      mips_isa_pkg::op_beq: begin
        rs_use = mips_pipe_pkg::STAGE_D;
        rt_use = mips_pipe_pkg::STAGE_D;
      end
      // Link value is PC+8, known already in D
      mips_isa_pkg::op_jal: begin
        dest        = mips_isa_pkg::REG_RA;
        ready_stage = mips_pipe_pkg::STAGE_D;
      end
      default: ;
    endcase
  end

  assign is_load  = (op == mips_isa_pkg::op_lw);
  assign is_store = (op == mips_isa_pkg::op_sw);
  assign imm_sign = is_load || is_store || (op == mips_isa_pkg::op_beq);

endmodule

// File: design/mips_isa_pkg.sv
package mips_isa_pkg;

  typedef logic [31:0] word_t;

  // R-type view of an instruction word
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_t;

  // op_nop stays at zero so a cleared stage decodes as a bubble
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_addu,
    op_subu,
    op_ori,
    op_lui,
    op_lw,
    op_sw,
    op_beq,
    op_j,
    op_jal
  } op_t;

  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_J       = 6'h02;
  localparam logic [5:0] OPC_JAL     = 6'h03;
  localparam logic [5:0] OPC_BEQ     = 6'h04;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_LUI     = 6'h0f;
  localparam logic [5:0] OPC_LW      = 6'h23;
  localparam logic [5:0] OPC_SW      = 6'h2b;

  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;

  localparam logic [4:0] REG_RA = 5'd31;

endpackage

// File: design/mips_pipe_pkg.sv
package mips_pipe_pkg;

  typedef logic [4:0] reg_idx_t;

  // Stage codes in pipeline order, zero means never
  typedef enum logic [2:0] {
    STAGE_NONE = 3'd0,
    STAGE_D    = 3'd1,
    STAGE_E    = 3'd2,
    STAGE_M    = 3'd3,
    STAGE_W    = 3'd4
  } stage_t;

  // Forward select codes
  localparam logic [1:0] FWD_RF = 2'd0;
  localparam logic [1:0] FWD_E  = 2'd1;
  localparam logic [1:0] FWD_M  = 2'd2;
  localparam logic [1:0] FWD_W  = 2'd3;

  typedef struct packed {
    mips_isa_pkg::word_t instr;
    mips_isa_pkg::word_t pc;
  } fd_payload_t;

  typedef struct packed {
    mips_isa_pkg::op_t   op;
    reg_idx_t            rs;
    reg_idx_t            rt;
    reg_idx_t            dest;
    mips_isa_pkg::word_t rs_val;
    mips_isa_pkg::word_t rt_val;
    mips_isa_pkg::word_t imm;
    stage_t              rs_use;
    stage_t              rt_use;
    stage_t              ready;
    mips_isa_pkg::word_t result;
    mips_isa_pkg::word_t pc;
    logic                is_load;
    logic                is_store;
  } de_payload_t;

  typedef struct packed {
    mips_isa_pkg::op_t   op;
    reg_idx_t            rt;
    reg_idx_t            dest;
    stage_t              ready;
    mips_isa_pkg::word_t result;
    mips_isa_pkg::word_t wdata;
    mips_isa_pkg::word_t pc;
  } em_payload_t;

  typedef struct packed {
    reg_idx_t            dest;
    logic                we;
    mips_isa_pkg::word_t result;
    mips_isa_pkg::word_t rdata;
    logic                is_load;
    mips_isa_pkg::word_t pc;
  } mw_payload_t;

endpackage

// File: design/pipe_reg.sv
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  logic     clear,
  input  payload_t d,
  output payload_t q
);

  // All-zero payload is a bubble
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// File: design/reg_file.sv
module reg_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    we,
  input  mips_pipe_pkg::reg_idx_t waddr,
  input  mips_isa_pkg::word_t     wdata,
  input  mips_pipe_pkg::reg_idx_t raddr1,
  input  mips_pipe_pkg::reg_idx_t raddr2,
  output mips_isa_pkg::word_t     rdata1,
  output mips_isa_pkg::word_t     rdata2
);

  mips_isa_pkg::word_t regs [1:31];

  // Register 0 reads zero, same-cycle write passes through
  function automatic mips_isa_pkg::word_t read_port(input mips_pipe_pkg::reg_idx_t addr);
    if (addr == '0) return '0;
    if (we && waddr == addr) return wdata;
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = read_port(raddr1);
  assign rdata2 = read_port(raddr2);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_mips -o tb_mips
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mips > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// File: sources.f
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/mips_decoder.sv
design/reg_file.sv
design/fetch_stage.sv
design/pipe_reg.sv
design/hazard_unit.sv
design/alu.sv
design/mips.sv
test/tb_mips.sv

// File: test/tb_mips.sv
module tb_mips;

  localparam mips_isa_pkg::word_t RESET_PC = 32'h0000_5000;
  localparam int MEM_WORDS   = 256;
  localparam int TRACE_LIMIT = 400;
  localparam int STEP_LIMIT  = 1000;

  logic                    clk;
  logic                    rst_n;
  logic                    fill_dmem;
  mips_isa_pkg::word_t     i_inst_rdata;
  mips_isa_pkg::word_t     m_data_rdata;
  mips_isa_pkg::word_t     i_inst_addr;
  mips_isa_pkg::word_t     m_data_addr;
  mips_isa_pkg::word_t     m_data_wdata;
  logic [3:0]              m_data_byteen;
  mips_isa_pkg::word_t     m_inst_addr;
  logic                    w_grf_we;
  mips_pipe_pkg::reg_idx_t w_grf_addr;
  mips_isa_pkg::word_t     w_grf_wdata;
  mips_isa_pkg::word_t     w_inst_addr;
  mips_isa_pkg::word_t     i_offset;

  mips_isa_pkg::word_t imem [0:MEM_WORDS-1];
  mips_isa_pkg::word_t dmem [0:MEM_WORDS-1];
  mips_isa_pkg::word_t prog [$];
  logic [31:0]         lcg_state;

  // Expected register writes and stores in program order
  mips_pipe_pkg::reg_idx_t exp_waddr [$];
  mips_isa_pkg::word_t     exp_wdata [$];
  mips_isa_pkg::word_t     exp_wpc [$];
  mips_isa_pkg::word_t     exp_saddr [$];
  mips_isa_pkg::word_t     exp_sdata [$];
  mips_isa_pkg::word_t     exp_spc [$];

  mips #(.RESET_PC(RESET_PC)) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_inst_rdata (i_inst_rdata),
    .m_data_rdata (m_data_rdata),
    .i_inst_addr  (i_inst_addr),
    .m_data_addr  (m_data_addr),
    .m_data_wdata (m_data_wdata),
    .m_data_byteen(m_data_byteen),
    .m_inst_addr  (m_inst_addr),
    .w_grf_we     (w_grf_we),
    .w_grf_addr   (w_grf_addr),
    .w_grf_wdata  (w_grf_wdata),
    .w_inst_addr  (w_inst_addr)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////
  // Memory models
  //////////////////////////////
  function automatic mips_isa_pkg::word_t fill_word(input logic [7:0] idx);
    mips_isa_pkg::word_t addr;
    addr = {22'd0, idx, 2'b00};
    return (addr * 32'h9e37_79b9) ^ 32'h0bad_f00d;
  endfunction

  // ROM covers 1 KB from RESET_PC and zeros decode as nops
  assign i_offset     = i_inst_addr - RESET_PC;
  assign i_inst_rdata = (i_offset[31:10] == '0) ? imem[i_offset[9:2]] : '0;
  // Reads return zero while the RAM is being filled
  assign m_data_rdata = fill_dmem ? '0 : dmem[m_data_addr[9:2]];

  always @(posedge clk) begin
    if (fill_dmem) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[8'(i)] <= fill_word(8'(i));
      end
    end else if (m_data_byteen != 4'h0) begin
      dmem[m_data_addr[9:2]] <= m_data_wdata;
    end
  end

  //////////////////////////////
  // Encoding and random numbers
  //////////////////////////////
  function automatic mips_isa_pkg::word_t r_type(input int rd, input int rs, input int rt,
                                                 input logic [5:0] fn);
    return {mips_isa_pkg::OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic mips_isa_pkg::word_t i_type(input logic [5:0] opc, input int rs,
                                                 input int rt, input int imm);
    return {opc, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // Target given as an instruction index from RESET_PC
  function automatic mips_isa_pkg::word_t j_type(input logic [5:0] opc, input int index);
    mips_isa_pkg::word_t addr;
    addr = RESET_PC + 32'(index * 4);
    return {opc, addr[27:2]};
  endfunction

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  //////////////////////////////
  // Checking
  //////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: %s is %h, expected %h", name, got, exp));
    end
  endtask

  // Program-order model with one delay slot after every branch and jump
  task automatic interpret_program();
    mips_isa_pkg::word_t regs [0:31];
    mips_isa_pkg::word_t ref_mem [0:MEM_WORDS-1];
    mips_isa_pkg::word_t pc, npc, nnpc, ins, a, b, res, addr, sext, end_pc;
    logic [4:0]          wreg;
    logic                wr;
    int                  steps;
    for (int i = 0; i < 32; i++) begin
      regs[5'(i)] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[8'(i)] = fill_word(8'(i));
    end
    exp_waddr.delete();
    exp_wdata.delete();
    exp_wpc.delete();
    exp_saddr.delete();
    exp_sdata.delete();
    exp_spc.delete();
    pc     = RESET_PC;
    npc    = RESET_PC + 32'd4;
    end_pc = RESET_PC + 32'(prog.size() * 4);
    steps  = 0;
    while (pc != end_pc) begin
      if (steps > STEP_LIMIT) begin
        stop_with_failure("Reference model did not reach the end of the program");
      end else begin
        ins  = imem[8'((pc - RESET_PC) >> 2)];
        a    = regs[ins[25:21]];
        b    = regs[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        nnpc = npc + 32'd4;
        wr   = 1'b0;
        wreg = ins[20:16];
        res  = '0;
        case (ins[31:26])
          mips_isa_pkg::OPC_SPECIAL: begin
            wreg = ins[15:11];
            if (ins[5:0] == mips_isa_pkg::FN_ADDU) begin
              wr  = 1'b1;
              res = a + b;
            end else if (ins[5:0] == mips_isa_pkg::FN_SUBU) begin
              wr  = 1'b1;
              res = a - b;
            end
          end
          mips_isa_pkg::OPC_ORI: begin
            wr  = 1'b1;
            res = a | {16'h0000, ins[15:0]};
          end
          mips_isa_pkg::OPC_LUI: begin
            wr  = 1'b1;
            res = {ins[15:0], 16'h0000};
          end
          mips_isa_pkg::OPC_LW: begin
            addr = a + sext;
            wr   = 1'b1;
            res  = ref_mem[addr[9:2]];
          end
          mips_isa_pkg::OPC_SW: begin
            addr = a + sext;
            ref_mem[addr[9:2]] = b;
            exp_saddr.push_back(addr);
            exp_sdata.push_back(b);
            exp_spc.push_back(pc);
          end
          mips_isa_pkg::OPC_BEQ: begin
            if (a == b) nnpc = npc + {sext[29:0], 2'b00};
          end
          mips_isa_pkg::OPC_J: nnpc = {npc[31:28], ins[25:0], 2'b00};
          mips_isa_pkg::OPC_JAL: begin
            nnpc = {npc[31:28], ins[25:0], 2'b00};
            wr   = 1'b1;
            wreg = 5'd31;
            res  = pc + 32'd8;
          end
          default: ;
        endcase
        // Register 0 shows on the trace but keeps zero
        if (wr) begin
          exp_waddr.push_back(wreg);
          exp_wdata.push_back(res);
          exp_wpc.push_back(pc);
          if (wreg != 5'd0) regs[wreg] = res;
        end
        pc = npc;
        npc = nnpc;
        steps++;
      end
    end
  endtask

  task automatic start_program();
    @(negedge clk);
    rst_n     = 1'b0;
    fill_dmem = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[8'(i)] = (i < prog.size()) ? prog[i] : '0;
    end
    interpret_program();
    repeat (3) @(negedge clk);
    check_value("i_inst_addr", i_inst_addr, RESET_PC);
    check_value("w_grf_we", 32'(w_grf_we), 32'h0);
    check_value("m_data_byteen", 32'(m_data_byteen), 32'h0);
    fill_dmem = 1'b0;
    rst_n     = 1'b1;
  endtask

  task automatic run_and_compare(input string name);
    int wi;
    int si;
    int cycles;
    wi = 0;
    si = 0;
    cycles = 0;
    while (wi < exp_waddr.size()) begin
      @(negedge clk);
      cycles++;
      if (cycles > TRACE_LIMIT) begin
        stop_with_failure($sformatf("Timeout: %s waited for write-back, got %0d of %0d writes",
                                    name, wi, exp_waddr.size()));
      end else begin
        if (m_data_byteen != 4'h0) begin
          if (si >= exp_saddr.size()) begin
            stop_with_failure($sformatf("%s made a store the program does not have", name));
          end else begin
            check_value("m_data_byteen", 32'(m_data_byteen), 32'hf);
            check_value("m_data_addr", m_data_addr, exp_saddr[si]);
            check_value("m_data_wdata", m_data_wdata, exp_sdata[si]);
            check_value("m_inst_addr", m_inst_addr, exp_spc[si]);
            si++;
          end
        end
        if (w_grf_we) begin
          check_value("w_grf_addr", 32'(w_grf_addr), 32'(exp_waddr[wi]));
          check_value("w_grf_wdata", w_grf_wdata, exp_wdata[wi]);
          check_value("w_inst_addr", w_inst_addr, exp_wpc[wi]);
          wi++;
        end
      end
    end
    check_value("store count", 32'(si), 32'(exp_saddr.size()));
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic random_alu_seq();
    logic [31:0] r;
    logic [31:0] imm;
    int          ra, rb, rc;
    prog.delete();
    for (int n = 0; n < 24; n++) begin
      r   = next_random();
      imm = next_random();
      // Eight registers keep dependencies close together
      ra  = int'(r[18:16]);
      rb  = int'(r[21:19]);
      rc  = int'(r[24:22]);
      case (r[26:25])
        2'd0:    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, ra, rb, int'(imm[31:16])));
        2'd1:    prog.push_back(i_type(mips_isa_pkg::OPC_LUI, 0, rb, int'(imm[31:16])));
        2'd2:    prog.push_back(r_type(rc, ra, rb, mips_isa_pkg::FN_ADDU));
        default: prog.push_back(r_type(rc, ra, rb, mips_isa_pkg::FN_SUBU));
      endcase
    end
    start_program();
    run_and_compare("random ALU sequence");
  endtask

  task automatic load_store_seq();
    prog.delete();
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 1, 'h40));
    prog.push_back(i_type(mips_isa_pkg::OPC_LUI, 0, 2, 'h1234));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 2, 2, 'h5678));
    prog.push_back(i_type(mips_isa_pkg::OPC_SW, 1, 2, 0));
    prog.push_back(i_type(mips_isa_pkg::OPC_SW, 1, 1, 8));
    prog.push_back(i_type(mips_isa_pkg::OPC_LW, 1, 3, 0));
    // Load-use stall
    prog.push_back(r_type(4, 3, 3, mips_isa_pkg::FN_ADDU));
    prog.push_back(i_type(mips_isa_pkg::OPC_LW, 1, 5, 4));
    prog.push_back(i_type(mips_isa_pkg::OPC_SW, 1, 5, 12));
    prog.push_back(i_type(mips_isa_pkg::OPC_LW, 1, 6, 12));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 0, 'h7777));
    prog.push_back(r_type(7, 0, 6, mips_isa_pkg::FN_ADDU));
    prog.push_back(i_type(mips_isa_pkg::OPC_LW, 1, 0, 8));
    prog.push_back(r_type(8, 0, 0, mips_isa_pkg::FN_ADDU));
    prog.push_back(r_type(9, 6, 4, mips_isa_pkg::FN_SUBU));
    start_program();
    run_and_compare("load and store");
  endtask

  task automatic branch_flow();
    prog.delete();
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 1, 5));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 2, 5));
    prog.push_back(i_type(mips_isa_pkg::OPC_BEQ, 1, 2, 3));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 3, 1));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 4, 'hbad));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 4, 'hbad));
    prog.push_back(i_type(mips_isa_pkg::OPC_BEQ, 1, 3, 2));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 5, 2));
    prog.push_back(j_type(mips_isa_pkg::OPC_J, 11));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 6, 3));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 4, 'hbad));
    prog.push_back(r_type(7, 5, 6, mips_isa_pkg::FN_ADDU));
    // beq two after a lw
    prog.push_back(i_type(mips_isa_pkg::OPC_LW, 0, 8, 'h10));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 9, 1));
    prog.push_back(i_type(mips_isa_pkg::OPC_BEQ, 8, 9, 2));
    prog.push_back(r_type(10, 8, 9, mips_isa_pkg::FN_ADDU));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 11, 4));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 12, 6));
    start_program();
    run_and_compare("branch and jump");
  endtask

  task automatic link_jump();
    prog.delete();
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 1, 1));
    prog.push_back(j_type(mips_isa_pkg::OPC_JAL, 5));
    // Delay slot reads the link register
    prog.push_back(r_type(2, 31, 0, mips_isa_pkg::FN_ADDU));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 4, 'hbad));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 4, 'hbad));
    prog.push_back(r_type(3, 31, 1, mips_isa_pkg::FN_ADDU));
    prog.push_back(r_type(5, 31, 2, mips_isa_pkg::FN_SUBU));
    prog.push_back(i_type(mips_isa_pkg::OPC_BEQ, 31, 2, 2));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 6, 7));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 4, 'hbad));
    prog.push_back(i_type(mips_isa_pkg::OPC_ORI, 0, 7, 8));
    start_program();
    run_and_compare("jump and link");
  endtask

  initial begin
    rst_n     = 1'b0;
    fill_dmem = 1'b1;
    lcg_state = 32'd84;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[8'(i)] = '0;
    end
    random_alu_seq();
    load_store_seq();
    branch_flow();
    link_jump();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
